//--- design/gf8_pkg.sv
// GF(8) arithmetic for the check-node stage
// symbols are 3-bit polynomials reduced by x^3+x+1

package gf8_pkg;

    // --------------------------------------------------
    // field shape
    // --------------------------------------------------
    localparam int GF_BITS = 3;

    // x^3 + x + 1, the top bit is implied by the shift
    localparam logic [GF_BITS:0] GF_POLY = 4'b1011;

    typedef logic [GF_BITS-1:0] gf_sym_t;

    // --------------------------------------------------
    // multiply by shift and reduce
    // --------------------------------------------------
    function automatic gf_sym_t gf_mul(gf_sym_t a, gf_sym_t b);
        gf_sym_t acc;
        gf_sym_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < GF_BITS; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            // multiply the running term by x
            sh = (sh << 1) ^ (sh[GF_BITS-1] ? GF_POLY[GF_BITS-1:0] : gf_sym_t'(0));
        end
        return acc;
    endfunction

    // multiplicative inverse, zero maps to zero
    function automatic gf_sym_t gf_inv(gf_sym_t w);
        gf_sym_t r;
        case (w)
            3'd1:    r = 3'd1;
            3'd2:    r = 3'd5;
            3'd3:    r = 3'd6;
            3'd4:    r = 3'd7;
            3'd5:    r = 3'd2;
            3'd6:    r = 3'd3;
            3'd7:    r = 3'd4;
            default: r = 3'd0;
        endcase
        return r;
    endfunction

    // --------------------------------------------------
    // divide, weight must be nonzero
    // --------------------------------------------------
    function automatic gf_sym_t gf_div(gf_sym_t s, gf_sym_t w);
        return gf_mul(s, gf_inv(w));
    endfunction

endpackage

//--- design/ldpc_code_pkg.sv
// code shape of the (20,10) non-binary LDPC code over GF(8)
// edge table plus the payload types passed between stages

package ldpc_code_pkg;

    import gf8_pkg::*;

    // --------------------------------------------------
    // dimensions
    // --------------------------------------------------
    localparam int N_VAR  = 20;
    localparam int N_CHK  = 10;
    localparam int N_EDGE = 60;

    // one edge of the Tanner graph
    typedef struct packed {
        logic [3:0] chk;
        logic [4:0] vn;
        gf_sym_t    weight;
    } edge_t;

    // --------------------------------------------------
    // edges, check-major, ascending variable per check
    // --------------------------------------------------
    localparam edge_t EDGE_TABLE [N_EDGE] = '{
        // check 0, weight 2
        '{4'd0, 5'd0, 3'd2},  '{4'd0, 5'd1, 3'd2},  '{4'd0, 5'd5, 3'd2},
        '{4'd0, 5'd10, 3'd2}, '{4'd0, 5'd12, 3'd2}, '{4'd0, 5'd13, 3'd2},
        // check 1, weight 4
        '{4'd1, 5'd4, 3'd4},  '{4'd1, 5'd6, 3'd4},  '{4'd1, 5'd8, 3'd4},
        '{4'd1, 5'd11, 3'd4}, '{4'd1, 5'd13, 3'd4}, '{4'd1, 5'd14, 3'd4},
        // check 2, weight 3
        '{4'd2, 5'd1, 3'd3},  '{4'd2, 5'd3, 3'd3},  '{4'd2, 5'd7, 3'd3},
        '{4'd2, 5'd10, 3'd3}, '{4'd2, 5'd14, 3'd3}, '{4'd2, 5'd15, 3'd3},
        // check 3, weight 6 on every edge
        '{4'd3, 5'd2, 3'd6},  '{4'd3, 5'd6, 3'd6},  '{4'd3, 5'd8, 3'd6},
        '{4'd3, 5'd12, 3'd6}, '{4'd3, 5'd15, 3'd6}, '{4'd3, 5'd16, 3'd6},
        // check 4, weight 7
        '{4'd4, 5'd3, 3'd7},  '{4'd4, 5'd9, 3'd7},  '{4'd4, 5'd11, 3'd7},
        '{4'd4, 5'd14, 3'd7}, '{4'd4, 5'd16, 3'd7}, '{4'd4, 5'd17, 3'd7},
        // check 5, weight 5
        '{4'd5, 5'd0, 3'd5},  '{4'd5, 5'd4, 3'd5},  '{4'd5, 5'd7, 3'd5},
        '{4'd5, 5'd13, 3'd5}, '{4'd5, 5'd17, 3'd5}, '{4'd5, 5'd18, 3'd5},
        // check 6, weight 2
        '{4'd6, 5'd2, 3'd2},  '{4'd6, 5'd6, 3'd2},  '{4'd6, 5'd9, 3'd2},
        '{4'd6, 5'd16, 3'd2}, '{4'd6, 5'd18, 3'd2}, '{4'd6, 5'd19, 3'd2},
        // check 7, weight 2, eight edges
        '{4'd7, 5'd3, 3'd2},  '{4'd7, 5'd5, 3'd2},  '{4'd7, 5'd8, 3'd2},
        '{4'd7, 5'd11, 3'd2}, '{4'd7, 5'd12, 3'd2}, '{4'd7, 5'd15, 3'd2},
        '{4'd7, 5'd17, 3'd2}, '{4'd7, 5'd19, 3'd2},
        // check 8, weight 4
        '{4'd8, 5'd1, 3'd4},  '{4'd8, 5'd5, 3'd4},  '{4'd8, 5'd7, 3'd4},
        '{4'd8, 5'd9, 3'd4},  '{4'd8, 5'd10, 3'd4}, '{4'd8, 5'd19, 3'd4},
        // check 9, weight 3, four edges
        '{4'd9, 5'd0, 3'd3},  '{4'd9, 5'd2, 3'd3},  '{4'd9, 5'd4, 3'd3},
        '{4'd9, 5'd18, 3'd3}
    };

    // --------------------------------------------------
    // payloads
    // --------------------------------------------------
    typedef gf_sym_t [N_VAR-1:0]  codeword_t;
    typedef gf_sym_t [N_EDGE-1:0] edge_prod_t;
    typedef gf_sym_t [N_CHK-1:0]  syndrome_t;

    typedef struct packed {
        logic                    parity_fail;
        gf_sym_t [N_EDGE-1:0]    msg;
    } check_result_t;

endpackage

//--- design/word_capture.sv
// four-phase receiver for incoming codewords
// holds one word until the check-node array takes it
`timescale 1ns/1ps

module word_capture (
    input  logic                     clk5,
    input  logic                     rst_n,
    input  logic                     in_req,
    output logic                     in_ack,
    input  ldpc_code_pkg::codeword_t in_word,
    output logic                     cap_valid,
    output ldpc_code_pkg::codeword_t cap_word,
    input  logic                     cap_take
);

    logic load;

    // new req phase, and room in the holding register
    assign load = in_req && !in_ack && (!cap_valid || cap_take);

    // --------------------------------------------------
    // handshake phase and valid flag
    // --------------------------------------------------
    always_ff @(posedge clk5 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_ack    <= 1'b0;
            cap_valid <= 1'b0;
        end
        else
        begin
            // ack stays up until the source lets go of req
            if (load)
                in_ack <= 1'b1;
            else if (!in_req)
                in_ack <= 1'b0;

            if (load)
                cap_valid <= 1'b1;
            else if (cap_take)
                cap_valid <= 1'b0;
        end
    end

    // word register
    always_ff @(posedge clk5)
    begin
        if (load)
            cap_word <= in_word;
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // ack must not drop before the source has dropped req
    ack_held_while_req: assert property (
        @(posedge clk5) disable iff (!rst_n)
        in_req && in_ack |=> in_ack
    );

endmodule

//--- design/check_node_array.sv
// check-node array: weighted edge products and check syndromes
// one item deep, stalls until the sender takes its result
`timescale 1ns/1ps

module check_node_array (
    input  logic                      clk5,
    input  logic                      rst_n,
    input  logic                      cap_valid,
    input  ldpc_code_pkg::codeword_t  cap_word,
    output logic                      cap_take,
    output logic                      syn_valid,
    output ldpc_code_pkg::syndrome_t  syn_word,
    output ldpc_code_pkg::edge_prod_t syn_prod,
    input  logic                      syn_take
);

    import gf8_pkg::*;
    import ldpc_code_pkg::*;

    edge_prod_t prod_next;
    syndrome_t  syn_next;

    // --------------------------------------------------
    // edge products
    // --------------------------------------------------
    for (genvar e = 0; e < N_EDGE; e++)
    begin : g_edge
        assign prod_next[e] = gf_mul(cap_word[EDGE_TABLE[e].vn], EDGE_TABLE[e].weight);
    end

    // syndromes, xor of all products on each check
    always_comb
    begin
        syn_next = '0;
        for (int e = 0; e < N_EDGE; e++)
        begin
            syn_next[EDGE_TABLE[e].chk] = syn_next[EDGE_TABLE[e].chk] ^ prod_next[e];
        end
    end

    // --------------------------------------------------
    // pipeline register
    // --------------------------------------------------
    // take a word when empty or when our item leaves this cycle
    assign cap_take = cap_valid && (!syn_valid || syn_take);

    always_ff @(posedge clk5 or negedge rst_n)
    begin
        if (!rst_n)
            syn_valid <= 1'b0;
        else if (cap_take)
            syn_valid <= 1'b1;
        else if (syn_take)
            syn_valid <= 1'b0;
    end

    // products and syndromes move together
    always_ff @(posedge clk5)
    begin
        if (cap_take)
        begin
            syn_word <= syn_next;
            syn_prod <= prod_next;
        end
    end

    // a waiting upstream word stays offered and unchanged until taken
    cap_held_until_taken: assert property (
        @(posedge clk5) disable iff (!rst_n)
        cap_valid && !cap_take |=> cap_valid && $stable(cap_word)
    );

endmodule

//--- design/message_sender.sv
// extrinsic check-to-variable messages and parity flag,
// sent out over a four-phase req/ack port
`timescale 1ns/1ps

module message_sender (
    input  logic                          clk5,
    input  logic                          rst_n,
    input  logic                          syn_valid,
    input  ldpc_code_pkg::syndrome_t      syn_word,
    input  ldpc_code_pkg::edge_prod_t     syn_prod,
    output logic                          syn_take,
    output logic                          out_req,
    input  logic                          out_ack,
    output ldpc_code_pkg::check_result_t  out_result
);

    import gf8_pkg::*;
    import ldpc_code_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_SEND,
        S_DONE
    } send_state_t;

    send_state_t   state;
    check_result_t result_next;

    // --------------------------------------------------
    // messages
    // --------------------------------------------------
    always_comb
    begin
        // any nonzero syndrome symbol fails parity
        result_next.parity_fail = |syn_word;
        for (int e = 0; e < N_EDGE; e++)
        begin
            // remove this edge's own term, then undo its weight
            result_next.msg[e] = gf_div(syn_word[EDGE_TABLE[e].chk] ^ syn_prod[e],
                                        EDGE_TABLE[e].weight);
        end
    end

    assign syn_take = syn_valid && (state == S_IDLE);

    // --------------------------------------------------
    // four-phase source
    // --------------------------------------------------
    always_ff @(posedge clk5 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= S_IDLE;
            out_req <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (syn_valid)
                        state <= S_LOAD;
                end
                S_LOAD:
                begin
                    out_req <= 1'b1;
                    state   <= S_SEND;
                end
                S_SEND:
                begin
                    if (out_ack)
                    begin
                        out_req <= 1'b0;
                        state   <= S_DONE;
                    end
                end
                // wait for the sink to release ack
                S_DONE:
                begin
                    if (!out_ack)
                        state <= S_IDLE;
                end
                default:
                begin
                    state   <= S_IDLE;
                    out_req <= 1'b0;
                end
            endcase
        end
    end

    // result register
    always_ff @(posedge clk5)
    begin
        if (syn_take)
            out_result <= result_next;
    end

    // data must stay put until the sink acknowledges
    result_stable_in_req: assert property (
        @(posedge clk5) disable iff (!rst_n)
        out_req && !out_ack |=> $stable(out_result)
    );

endmodule

//--- design/nb_ldpc_check_top.sv
// check-node stage of a GF(8) LDPC decoder
// capture, syndrome and message stages in a three-deep pipeline
`timescale 1ns/1ps

module nb_ldpc_check_top (
    input  logic                          clk5,
    input  logic                          rst_n,
    // codeword in
    input  logic                          in_req,
    output logic                          in_ack,
    input  ldpc_code_pkg::codeword_t      in_word,
    // results out
    output logic                          out_req,
    input  logic                          out_ack,
    output ldpc_code_pkg::check_result_t  out_result
);

    import ldpc_code_pkg::*;

    logic       cap_valid;
    logic       cap_take;
    codeword_t  cap_word;

    logic       syn_valid;
    logic       syn_take;
    syndrome_t  syn_word;
    edge_prod_t syn_prod;

    // --------------------------------------------------
    // stages
    // --------------------------------------------------
    word_capture u_capture (
        .clk5      (clk5),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_word   (in_word),
        .cap_valid (cap_valid),
        .cap_word  (cap_word),
        .cap_take  (cap_take)
    );

    check_node_array u_checks (
        .clk5      (clk5),
        .rst_n     (rst_n),
        .cap_valid (cap_valid),
        .cap_word  (cap_word),
        .cap_take  (cap_take),
        .syn_valid (syn_valid),
        .syn_word  (syn_word),
        .syn_prod  (syn_prod),
        .syn_take  (syn_take)
    );

    message_sender u_sender (
        .clk5       (clk5),
        .rst_n      (rst_n),
        .syn_valid  (syn_valid),
        .syn_word   (syn_word),
        .syn_prod   (syn_prod),
        .syn_take   (syn_take),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_result (out_result)
    );

endmodule

//--- test/tb_ref_model.svh
// reference model for the GF(8) check-node stage
// own field arithmetic, kept apart from the design packages
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// --------------------------------------------------
// field arithmetic modulo x^3+x+1
// --------------------------------------------------
function automatic logic [2:0] field_mul(logic [2:0] a, logic [2:0] b);
    logic [4:0] wide;
    wide = '0;
    for (int i = 0; i < 3; i++)
    begin
        if (b[i])
            wide = wide ^ ({2'b00, a} << i);
    end
    // fold x^4 and x^3 back down, x^3 = x + 1
    for (int k = 4; k >= 3; k--)
    begin
        if (wide[k])
            wide = wide ^ (5'b01011 << (k - 3));
    end
    return wide[2:0];
endfunction

// inverse found by trying every nonzero element
function automatic logic [2:0] field_div(logic [2:0] s, logic [2:0] w);
    logic [2:0] inv;
    inv = '0;
    for (logic [3:0] v = 1; v < 8; v++)
    begin
        if (field_mul(w, v[2:0]) == 3'd1)
            inv = v[2:0];
    end
    return field_mul(s, inv);
endfunction

// --------------------------------------------------
// expected parity flag and extrinsic messages
// --------------------------------------------------
function automatic check_result_t expected_result(codeword_t w);
    logic [2:0]    prod [N_EDGE];
    logic [2:0]    syn [N_CHK];
    check_result_t r;
    for (int c = 0; c < N_CHK; c++)
        syn[c] = '0;
    for (int e = 0; e < N_EDGE; e++)
    begin
        prod[e] = field_mul(w[EDGE_TABLE[e].vn], EDGE_TABLE[e].weight);
        syn[EDGE_TABLE[e].chk] = syn[EDGE_TABLE[e].chk] ^ prod[e];
    end
    r.parity_fail = 1'b0;
    for (int c = 0; c < N_CHK; c++)
    begin
        if (syn[c] != 3'd0)
            r.parity_fail = 1'b1;
    end
    // syndrome without the edge's own term, then divide out its weight
    for (int e = 0; e < N_EDGE; e++)
        r.msg[e] = field_div(syn[EDGE_TABLE[e].chk] ^ prod[e], EDGE_TABLE[e].weight);
    return r;
endfunction

`endif

//--- test/nb_ldpc_check_tb.sv
// testbench for the GF(8) LDPC check-node stage
// four-phase source and sink, every result compared with the reference
`timescale 1ns/1ps

module nb_ldpc_check_tb;

    import ldpc_code_pkg::*;

    localparam int N_RANDOM = 200;
    localparam int N_WORDS  = 1 + N_VAR + N_RANDOM;
    localparam int TIMEOUT  = 400;
    localparam int CMP_W    = $bits(check_result_t);

    logic          clk5;
    logic          rst_n;
    logic          in_req;
    logic          in_ack;
    codeword_t     in_word;
    logic          out_req;
    logic          out_ack;
    check_result_t out_result;

    check_result_t expected_q [$];
    int            error_count;
    int            results_seen;

    `include "tb_ref_model.svh"

    nb_ldpc_check_top u_dut (
        .clk5       (clk5),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_word    (in_word),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_result (out_result)
    );

    initial
    begin
        clk5 = 1'b0;
        forever #4 clk5 = ~clk5;
    end

    // --------------------------------------------------
    // checking and end of run
    // --------------------------------------------------
    task automatic check_value(string name, logic [CMP_W-1:0] got, logic [CMP_W-1:0] exp);
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("results checked: %0d of %0d, errors: %0d", results_seen, N_WORDS, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    task automatic report_timeout(string what);
        error_count++;
        $display("timeout: %s", what);
        finish_run();
    endtask

    task automatic compare_result(check_result_t got, check_result_t exp);
        check_value("out_result.parity_fail", got.parity_fail, exp.parity_fail);
        for (int e = 0; e < N_EDGE; e++)
            check_value($sformatf("out_result.msg[%0d]", e), got.msg[e], exp.msg[e]);
    endtask

    // --------------------------------------------------
    // four-phase source
    // --------------------------------------------------
    task automatic send_word(codeword_t w);
        int waited;
        expected_q.push_back(expected_result(w));
        @(negedge clk5);
        in_word = w;
        in_req  = 1'b1;
        waited  = 0;
        while (in_ack !== 1'b1)
        begin
            @(negedge clk5);
            waited++;
            if (waited > TIMEOUT)
                report_timeout("in_ack never rose for a pending word");
        end
        in_req = 1'b0;
        waited = 0;
        while (in_ack !== 1'b0)
        begin
            @(negedge clk5);
            waited++;
            if (waited > TIMEOUT)
                report_timeout("in_ack stayed high after in_req fell");
        end
    endtask

    // sink with random ack delays, long ones fill the pipeline
    task automatic run_sink();
        int waited;
        int delay;
        for (int n = 0; n < N_WORDS; n++)
        begin
            waited = 0;
            while (out_req !== 1'b1)
            begin
                @(negedge clk5);
                waited++;
                if (waited > TIMEOUT)
                    report_timeout("out_req never rose for an expected result");
            end
            if ($urandom_range(0, 3) == 0)
                delay = $urandom_range(8, 24);
            else
                delay = $urandom_range(0, 3);
            repeat (delay) @(negedge clk5);
            out_ack = 1'b1;
            waited  = 0;
            while (out_req !== 1'b0)
            begin
                @(negedge clk5);
                waited++;
                if (waited > TIMEOUT)
                    report_timeout("out_req stayed high after out_ack rose");
            end
            out_ack = 1'b0;
        end
    endtask

    // one compare per out_req rise, then hold check until req drops
    task automatic run_compare();
        check_result_t exp_res;
        check_result_t held;
        logic          req_prev;
        int            idle;
        req_prev = 1'b0;
        idle     = 0;
        held     = '0;
        while (results_seen < N_WORDS)
        begin
            @(negedge clk5);
            if (out_req && !req_prev)
            begin
                idle = 0;
                held = out_result;
                if (expected_q.size() == 0)
                begin
                    error_count++;
                    $display("a result arrived while no word was outstanding");
                end
                else
                begin
                    exp_res = expected_q.pop_front();
                    compare_result(out_result, exp_res);
                end
                results_seen++;
            end
            else if (out_req)
            begin
                idle = 0;
                check_value("out_result while out_req high", out_result, held);
            end
            else
            begin
                idle++;
                if (idle > TIMEOUT)
                    report_timeout("no result came out of the DUT");
            end
            req_prev = out_req;
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial
    begin : main_flow
        codeword_t w;
        int        waited;
        int        seed_val;
        seed_val     = $urandom(32'h5459_feef);
        error_count  = 0;
        results_seen = 0;
        rst_n        = 1'b0;
        in_req       = 1'b0;
        in_word      = '0;
        out_ack      = 1'b0;
        repeat (2) @(posedge clk5);
        @(negedge clk5);
        rst_n = 1'b1;

        // both handshakes idle out of reset
        check_value("in_ack", in_ack, 1'b0);
        check_value("out_req", out_req, 1'b0);

        fork
            run_sink();
            run_compare();
        join_none

        // all-zero codeword
        send_word('0);

        // single nonzero symbol, walked across every variable
        for (int v = 0; v < N_VAR; v++)
        begin
            w    = '0;
            w[v] = 3'((v % 7) + 1);
            send_word(w);
        end

        for (int n = 0; n < N_RANDOM; n++)
        begin
            for (int v = 0; v < N_VAR; v++)
                w[v] = 3'($urandom_range(0, 7));
            send_word(w);
        end

        waited = 0;
        while (results_seen < N_WORDS)
        begin
            @(negedge clk5);
            waited++;
            if (waited > TIMEOUT)
                report_timeout("results still missing after the last word");
        end

        // nothing more may come out
        repeat (20) @(negedge clk5);
        check_value("out_req after last result", out_req, 1'b0);
        check_value("expected results left over", expected_q.size(), 0);
        finish_run();
    end

endmodule

//--- nb_ldpc_check.f
+incdir+test
design/gf8_pkg.sv
design/ldpc_code_pkg.sv
design/word_capture.sv
design/check_node_array.sv
design/message_sender.sv
design/nb_ldpc_check_top.sv
test/nb_ldpc_check_tb.sv

//--- Bender.yml
package:
  name: nb_ldpc_check

sources:
  # design sources in compile order
  - files:
      - design/gf8_pkg.sv
      - design/ldpc_code_pkg.sv
      - design/word_capture.sv
      - design/check_node_array.sv
      - design/message_sender.sv
      - design/nb_ldpc_check_top.sv

  # testbench, pulls in the reference model header
  - target: test
    include_dirs:
      - test
    files:
      - test/nb_ldpc_check_tb.sv
